// File: common/mm_ram_config.svh
/*
 * mm_ram configuration
 * address map of the RAM wrapper, SRAM size, boot ROM instruction
 * and the interrupt line used by the countdown timer
 */

`ifndef MM_RAM_CONFIG_SVH
`define MM_RAM_CONFIG_SVH

// boot ROM, every word reads as the same instruction
`define MM_ROM_BASE        32'h0000_0000
`define MM_ROM_LEN         32'h0000_0100
`define MM_ROM_INSTR       32'h0000_006F

// dual-port SRAM
`define MM_SRAM_BASE       32'h0010_0000
`define MM_SRAM_LEN        32'h0001_0000
`define MM_RAM_ADDR_WIDTH  16

// countdown timer, offset 0 is the mask and offset 4 the count
`define MM_TIMER_BASE      32'h1500_0000
`define MM_TIMER_LEN       32'h0000_0008
`define MM_TIMER_IRQ_ID    3

// stdout character sink
`define MM_STDOUT_BASE     32'h1A10_F000
`define MM_STDOUT_LEN      32'h0000_1000

`endif

// File: common/mm_ram_pkg.sv
/*
 * mm_ram package
 * bus word types shared by the RAM wrapper blocks and the testbench,
 * plus the region encoding that selects the read data of a response
 */

package mm_ram_pkg;

    // byte address as seen by the core
    typedef logic [31:0] addr_t;

    // one bus word
    typedef logic [31:0] data_t;

    // one enable per byte lane
    typedef logic [3:0] be_t;

    // source of a port's read data in the response cycle
    typedef enum logic [2:0] {
        RGN_IDLE       = 3'd0,
        RGN_RAM        = 3'd1,
        RGN_ROM        = 3'd2,
        RGN_TIMER_MASK = 3'd3,
        RGN_TIMER_CNT  = 3'd4,
        RGN_UNMAP      = 3'd5
    } region_e;

    // true when addr falls in [base, base + len)
    function automatic logic in_region(addr_t addr, addr_t base, addr_t len);
        return (addr >= base) && ((addr - base) < len);
    endfunction

endpackage

// File: ram/dp_ram.sv
/*
 * dp_ram
 * word-organised dual-port SRAM, port A reads only, port B reads or
 * writes with byte enables, read data registered on both ports
 */

`timescale 1ns/100ps

module dp_ram
    import mm_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk_i,

    input  logic                  en_a_i,
    input  logic [ADDR_WIDTH-1:0] addr_a_i,
    output data_t                 rdata_a_o,

    input  logic                  en_b_i,
    input  logic [ADDR_WIDTH-1:0] addr_b_i,
    input  logic                  we_b_i,
    input  be_t                   be_b_i,
    input  data_t                 wdata_b_i,
    output data_t                 rdata_b_o
);

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    data_t mem [WORDS];

    // byte address, the two low bits are ignored
    logic [ADDR_WIDTH-3:0] word_a;
    logic [ADDR_WIDTH-3:0] word_b;

    assign word_a = addr_a_i[ADDR_WIDTH-1:2];
    assign word_b = addr_b_i[ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            rdata_a_o <= mem[word_a];
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_b_i) begin
            if (we_b_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (be_b_i[i]) begin
                        mem[word_b][i*8 +: 8] <= wdata_b_i[i*8 +: 8];
                    end
                end
            end else begin
                rdata_b_o <= mem[word_b];
            end
        end
    end

endmodule

// File: hdl/mm_decoder.sv
/*
 * mm_decoder
 * decodes both core ports against the address map, steers accesses to
 * the SRAM ports and timer, and registers rvalid, read select and stdout
 */

`timescale 1ns/100ps

`include "mm_ram_config.svh"

module mm_decoder
    import mm_ram_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          instr_req_i,
    input  addr_t                         instr_addr_i,
    input  logic                          data_req_i,
    input  addr_t                         data_addr_i,
    input  logic                          data_we_i,
    input  be_t                           data_be_i,
    input  data_t                         data_wdata_i,

    output logic                          instr_gnt_o,
    output logic                          data_gnt_o,
    output logic                          instr_rvalid_o,
    output logic                          data_rvalid_o,

    output logic                          ram_a_en_o,
    output logic [`MM_RAM_ADDR_WIDTH-1:0] ram_a_addr_o,
    output logic                          ram_b_en_o,
    output logic [`MM_RAM_ADDR_WIDTH-1:0] ram_b_addr_o,
    output logic                          ram_b_we_o,
    output be_t                           ram_b_be_o,
    output data_t                         ram_b_wdata_o,

    output logic                          timer_mask_we_o,
    output logic                          timer_cnt_we_o,
    output data_t                         timer_wdata_o,

    output region_e                       instr_sel_o,
    output region_e                       data_sel_o,

    output logic                          print_valid_o,
    output logic [7:0]                    print_char_o
);

    logic    instr_ram_hit;
    logic    instr_rom_hit;
    logic    data_ram_hit;
    logic    data_rom_hit;
    logic    data_timer_hit;
    logic    data_stdout_hit;
    logic    data_wr;

    region_e instr_sel_d;
    region_e data_sel_d;
    region_e instr_sel_q;
    region_e data_sel_q;
    logic    instr_rvalid_q;
    logic    data_rvalid_q;
    logic    print_valid_q;
    logic [7:0] print_char_q;

    // address decode, fetches only see SRAM and ROM
    assign instr_ram_hit   = in_region(instr_addr_i, `MM_SRAM_BASE, `MM_SRAM_LEN);
    assign instr_rom_hit   = in_region(instr_addr_i, `MM_ROM_BASE, `MM_ROM_LEN);
    assign data_ram_hit    = in_region(data_addr_i, `MM_SRAM_BASE, `MM_SRAM_LEN);
    assign data_rom_hit    = in_region(data_addr_i, `MM_ROM_BASE, `MM_ROM_LEN);
    assign data_timer_hit  = in_region(data_addr_i, `MM_TIMER_BASE, `MM_TIMER_LEN);
    assign data_stdout_hit = in_region(data_addr_i, `MM_STDOUT_BASE, `MM_STDOUT_LEN);

    assign data_wr = data_req_i & data_we_i;

    // ports never conflict, so every request is granted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    // SRAM base is aligned to its size, the low bits are the offset
    assign ram_a_en_o    = instr_req_i & instr_ram_hit;
    assign ram_a_addr_o  = instr_addr_i[`MM_RAM_ADDR_WIDTH-1:0];
    assign ram_b_en_o    = data_req_i & data_ram_hit;
    assign ram_b_addr_o  = data_addr_i[`MM_RAM_ADDR_WIDTH-1:0];
    assign ram_b_we_o    = data_wr & data_ram_hit;
    assign ram_b_be_o    = data_be_i;
    assign ram_b_wdata_o = data_wdata_i;

    // timer register writes, bit 2 picks mask or count
    assign timer_mask_we_o = data_wr & data_timer_hit & ~data_addr_i[2];
    assign timer_cnt_we_o  = data_wr & data_timer_hit & data_addr_i[2];
    assign timer_wdata_o   = data_wdata_i;

    always_comb begin
        if (!instr_req_i) begin
            instr_sel_d = RGN_IDLE;
        end else if (instr_ram_hit) begin
            instr_sel_d = RGN_RAM;
        end else if (instr_rom_hit) begin
            instr_sel_d = RGN_ROM;
        end else begin
            instr_sel_d = RGN_UNMAP;
        end
    end

    // writes answer with zero data, so they select idle
    always_comb begin
        if (!data_req_i || data_we_i) begin
            data_sel_d = RGN_IDLE;
        end else if (data_ram_hit) begin
            data_sel_d = RGN_RAM;
        end else if (data_rom_hit) begin
            data_sel_d = RGN_ROM;
        end else if (data_timer_hit) begin
            data_sel_d = data_addr_i[2] ? RGN_TIMER_CNT : RGN_TIMER_MASK;
        end else begin
            data_sel_d = RGN_UNMAP;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_sel_q    <= RGN_IDLE;
            data_sel_q     <= RGN_IDLE;
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
            print_valid_q  <= 1'b0;
        end else begin
            instr_sel_q    <= instr_sel_d;
            data_sel_q     <= data_sel_d;
            instr_rvalid_q <= instr_req_i;
            data_rvalid_q  <= data_req_i;
            print_valid_q  <= data_wr & data_stdout_hit;
        end
    end

    // character byte only loads on a stdout write
    always_ff @(posedge clk_i) begin
        if (data_wr && data_stdout_hit) begin
            print_char_q <= data_wdata_i[7:0];
        end
    end

    assign instr_sel_o    = instr_sel_q;
    assign data_sel_o     = data_sel_q;
    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;
    assign print_valid_o  = print_valid_q;
    assign print_char_o   = print_char_q;

endmodule

// File: hdl/mm_timer.sv
/*
 * mm_timer
 * countdown timer with an interrupt mask, raises its interrupt when
 * the count steps from 1 to 0 and clears it on a matching acknowledge
 */

`timescale 1ns/100ps

`include "mm_ram_config.svh"

module mm_timer
    import mm_ram_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       mask_we_i,
    input  logic       cnt_we_i,
    input  data_t      wdata_i,

    input  logic       irq_ack_i,
    input  logic [4:0] irq_id_i,

    output data_t      mask_o,
    output data_t      cnt_o,
    output logic       irq_o
);

    data_t mask_q;
    data_t cnt_q;
    logic  irq_q;
    logic  expire;
    logic  ack;

    // count about to step 1 -> 0, unless software reloads it
    assign expire = !cnt_we_i && (cnt_q == 32'd1) && mask_q[`MM_TIMER_IRQ_ID];
    assign ack    = irq_ack_i && (irq_id_i == 5'(`MM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            if (mask_we_i) begin
                mask_q <= wdata_i;
            end

            // a count write wins over the decrement
            if (cnt_we_i) begin
                cnt_q <= wdata_i;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 32'd1;
            end

            // a fresh expiry beats an ack of the previous one
            if (expire) begin
                irq_q <= 1'b1;
            end else if (ack) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign mask_o = mask_q;
    assign cnt_o  = cnt_q;
    assign irq_o  = irq_q;

endmodule

// File: hdl/mm_rsp_mux.sv
/*
 * mm_rsp_mux
 * picks each port's read data from the select registered by the decoder
 */

`timescale 1ns/100ps

`include "mm_ram_config.svh"

module mm_rsp_mux
    import mm_ram_pkg::*;
(
    input  region_e instr_sel_i,
    input  region_e data_sel_i,

    input  data_t   ram_a_rdata_i,
    input  data_t   ram_b_rdata_i,
    input  data_t   timer_mask_i,
    input  data_t   timer_cnt_i,

    output data_t   instr_rdata_o,
    output data_t   data_rdata_o
);

    // same selection for both ports, only the RAM word differs
    function automatic data_t pick(region_e sel, data_t ram_rdata,
                                   data_t mask, data_t cnt);
        data_t rdata;
        case (sel)
            RGN_RAM:        rdata = ram_rdata;
            RGN_ROM:        rdata = `MM_ROM_INSTR;
            RGN_TIMER_MASK: rdata = mask;
            RGN_TIMER_CNT:  rdata = cnt;
            // idle, unmapped and writes read as zero
            default:        rdata = '0;
        endcase
        return rdata;
    endfunction

    assign instr_rdata_o = pick(instr_sel_i, ram_a_rdata_i, timer_mask_i, timer_cnt_i);
    assign data_rdata_o  = pick(data_sel_i, ram_b_rdata_i, timer_mask_i, timer_cnt_i);

endmodule

// File: hdl/mm_ram.sv
/*
 * mm_ram
 * memory-mapped RAM wrapper for a small RISC-V core, with an instruction
 * port and a data port, dual-port SRAM, boot ROM, stdout and a timer
 */

`timescale 1ns/100ps

`include "mm_ram_config.svh"

module mm_ram
    import mm_ram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic        instr_req_i,
    input  addr_t       instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output data_t       instr_rdata_o,

    input  logic        data_req_i,
    input  addr_t       data_addr_i,
    input  logic        data_we_i,
    input  be_t         data_be_i,
    input  data_t       data_wdata_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output data_t       data_rdata_o,

    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i,
    output logic        irq_o,

    output logic        print_valid_o,
    output logic [7:0]  print_char_o
);

    // decoder to SRAM
    logic                          ram_a_en;
    logic [`MM_RAM_ADDR_WIDTH-1:0] ram_a_addr;
    logic                          ram_b_en;
    logic [`MM_RAM_ADDR_WIDTH-1:0] ram_b_addr;
    logic                          ram_b_we;
    be_t                           ram_b_be;
    data_t                         ram_b_wdata;
    data_t                         ram_a_rdata;
    data_t                         ram_b_rdata;

    // decoder to timer
    logic                          timer_mask_we;
    logic                          timer_cnt_we;
    data_t                         timer_wdata;
    data_t                         timer_mask;
    data_t                         timer_cnt;

    // registered read data selects
    region_e                       instr_sel;
    region_e                       data_sel;

    mm_decoder i_mm_decoder (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .instr_req_i     (instr_req_i),
        .instr_addr_i    (instr_addr_i),
        .data_req_i      (data_req_i),
        .data_addr_i     (data_addr_i),
        .data_we_i       (data_we_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .instr_gnt_o     (instr_gnt_o),
        .data_gnt_o      (data_gnt_o),
        .instr_rvalid_o  (instr_rvalid_o),
        .data_rvalid_o   (data_rvalid_o),
        .ram_a_en_o      (ram_a_en),
        .ram_a_addr_o    (ram_a_addr),
        .ram_b_en_o      (ram_b_en),
        .ram_b_addr_o    (ram_b_addr),
        .ram_b_we_o      (ram_b_we),
        .ram_b_be_o      (ram_b_be),
        .ram_b_wdata_o   (ram_b_wdata),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .instr_sel_o     (instr_sel),
        .data_sel_o      (data_sel),
        .print_valid_o   (print_valid_o),
        .print_char_o    (print_char_o)
    );

    dp_ram #(
        .ADDR_WIDTH (`MM_RAM_ADDR_WIDTH)
    ) i_dp_ram (
        .clk_i     (clk_i),
        .en_a_i    (ram_a_en),
        .addr_a_i  (ram_a_addr),
        .rdata_a_o (ram_a_rdata),
        .en_b_i    (ram_b_en),
        .addr_b_i  (ram_b_addr),
        .we_b_i    (ram_b_we),
        .be_b_i    (ram_b_be),
        .wdata_b_i (ram_b_wdata),
        .rdata_b_o (ram_b_rdata)
    );

    mm_timer i_mm_timer (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .mask_we_i (timer_mask_we),
        .cnt_we_i  (timer_cnt_we),
        .wdata_i   (timer_wdata),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .mask_o    (timer_mask),
        .cnt_o     (timer_cnt),
        .irq_o     (irq_o)
    );

    mm_rsp_mux i_mm_rsp_mux (
        .instr_sel_i   (instr_sel),
        .data_sel_i    (data_sel),
        .ram_a_rdata_i (ram_a_rdata),
        .ram_b_rdata_i (ram_b_rdata),
        .timer_mask_i  (timer_mask),
        .timer_cnt_i   (timer_cnt),
        .instr_rdata_o (instr_rdata_o),
        .data_rdata_o  (data_rdata_o)
    );

endmodule

// File: verification/tb_clk_gen.sv
/*
 * tb_clk_gen
 * testbench clock and reset, 20 ns period, reset held low for 5 cycles
 */

`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the active edge
    initial begin
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: verification/tb_mm_ram.sv
/*
 * tb_mm_ram
 * directed testbench for the RAM wrapper, covers SRAM, boot ROM,
 * unmapped space, stdout and the countdown timer interrupt
 */

`timescale 1ns/100ps

`include "mm_ram_config.svh"

module tb_mm_ram
    import mm_ram_pkg::*;
();

    localparam int    TIMEOUT  = 20;
    localparam int    TICKS    = 20;
    localparam data_t ROM_WORD = 32'h0000_006F;

    logic       clk;
    logic       rst_n;
    logic       instr_req;
    addr_t      instr_addr;
    logic       instr_gnt;
    logic       instr_rvalid;
    data_t      instr_rdata;
    logic       data_req;
    addr_t      data_addr;
    logic       data_we;
    be_t        data_be;
    data_t      data_wdata;
    logic       data_gnt;
    logic       data_rvalid;
    data_t      data_rdata;
    logic       irq_ack;
    logic [4:0] irq_id;
    logic       irq;
    logic       print_valid;
    logic [7:0] print_char;

    // expected SRAM contents by word address
    data_t ram_model [addr_t];
    addr_t addrs [8];

    tb_clk_gen i_tb_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mm_ram i_mm_ram (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .irq_ack_i      (irq_ack),
        .irq_id_i       (irq_id),
        .irq_o          (irq),
        .print_valid_o  (print_valid),
        .print_char_o   (print_char)
    );

    task automatic abort(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            abort($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // byte lanes with their enable set take the new data
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // one request on either port and its response data
    task automatic access(input bit on_instr, input logic we, input addr_t addr,
                          input be_t be, input data_t wdata, output data_t rdata);
        int   cycles;
        logic valid;
        @(negedge clk);
        if (on_instr) begin
            instr_req  = 1'b1;
            instr_addr = addr;
        end else begin
            data_req   = 1'b1;
            data_addr  = addr;
            data_we    = we;
            data_be    = be;
            data_wdata = wdata;
        end
        #1;
        check_bit(on_instr ? "instr_gnt_o" : "data_gnt_o",
                  on_instr ? instr_gnt : data_gnt, 1'b1);
        cycles = 0;
        valid  = 1'b0;
        while (!valid && cycles < TIMEOUT) begin
            @(negedge clk);
            instr_req = 1'b0;
            data_req  = 1'b0;
            data_we   = 1'b0;
            cycles++;
            valid = on_instr ? instr_rvalid : data_rvalid;
        end
        if (!valid) begin
            abort("no rvalid arrived after a granted request");
        end
        if (cycles != 1) begin
            abort("rvalid did not arrive exactly one cycle after the request");
        end
        rdata = on_instr ? instr_rdata : data_rdata;
    endtask

    task automatic write_word(input addr_t addr, input be_t be, input data_t wdata);
        data_t rdata;
        access(1'b0, 1'b1, addr, be, wdata, rdata);
        check_data("data_rdata_o", rdata, '0);
    endtask

    task automatic read_word(input bit on_instr, input addr_t addr, input data_t expected);
        data_t rdata;
        access(on_instr, 1'b0, addr, 4'hF, '0, rdata);
        check_data(on_instr ? "instr_rdata_o" : "data_rdata_o", rdata, expected);
    endtask

    task automatic reset_state_test();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            abort("reset was never released");
        end
        check_bit("instr_rvalid_o", instr_rvalid, 1'b0);
        check_bit("data_rvalid_o", data_rvalid, 1'b0);
        check_bit("print_valid_o", print_valid, 1'b0);
        check_bit("irq_o", irq, 1'b0);
    endtask

    task automatic sram_test();
        data_t word;
        be_t   be;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = `MM_SRAM_BASE + 32'(i * 'h104);
            word = $urandom;
            write_word(addrs[i], 4'hF, word);
            ram_model[addrs[i]] = word;
        end
        // partial writes over the full words
        for (int i = 0; i < 8; i++) begin
            word = $urandom;
            be   = be_t'($urandom_range(14, 1));
            write_word(addrs[i], be, word);
            ram_model[addrs[i]] = merge_bytes(ram_model[addrs[i]], word, be);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(1'b0, addrs[i], ram_model[addrs[i]]);
            read_word(1'b1, addrs[i], ram_model[addrs[i]]);
        end
        // back to back reads with one response per cycle
        @(negedge clk);
        for (int i = 0; i <= 8; i++) begin
            if (i < 8) begin
                data_req  = 1'b1;
                data_we   = 1'b0;
                data_addr = addrs[i];
            end else begin
                data_req = 1'b0;
            end
            if (i > 0) begin
                check_bit("data_rvalid_o", data_rvalid, 1'b1);
                check_data("data_rdata_o", data_rdata, ram_model[addrs[i-1]]);
            end
            @(negedge clk);
        end
        check_bit("data_rvalid_o", data_rvalid, 1'b0);
    endtask

    task automatic rom_unmapped_test();
        addr_t target;
        read_word(1'b0, `MM_ROM_BASE + 32'h10, ROM_WORD);
        read_word(1'b1, `MM_ROM_BASE + 32'h20, ROM_WORD);
        read_word(1'b0, 32'h2000_0000, '0);
        // timer and stdout are not visible to fetches
        read_word(1'b1, `MM_TIMER_BASE, '0);
        read_word(1'b1, `MM_STDOUT_BASE, '0);
        // unmapped write sharing the low bits of an SRAM word
        target = addrs[1];
        write_word(32'h3000_0000 | (target & 32'hFFFF), 4'hF, ~ram_model[target]);
        read_word(1'b0, target, ram_model[target]);
    endtask

    task automatic stdout_test();
        data_t word;
        int    cycles;
        word = $urandom;
        @(negedge clk);
        data_req   = 1'b1;
        data_we    = 1'b1;
        data_be    = 4'hF;
        data_addr  = `MM_STDOUT_BASE;
        data_wdata = word;
        cycles = 0;
        while (!print_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            data_req = 1'b0;
            data_we  = 1'b0;
            cycles++;
        end
        if (!print_valid) begin
            abort("print_valid_o never rose after a stdout write");
        end
        if (cycles != 1) begin
            abort("print_valid_o did not follow the stdout write by one cycle");
        end
        check_data("print_char_o", data_t'(print_char), data_t'(word[7:0]));
        @(negedge clk);
        check_bit("print_valid_o", print_valid, 1'b0);
    endtask

    task automatic timer_irq_test();
        int cycles;
        write_word(`MM_TIMER_BASE, 4'hF, 32'h8);
        read_word(1'b0, `MM_TIMER_BASE, 32'h8);
        write_word(`MM_TIMER_BASE + 32'h4, 4'hF, TICKS);
        // two decrements between the load edge and the sampled response
        read_word(1'b0, `MM_TIMER_BASE + 32'h4, TICKS - 2);
        check_bit("irq_o", irq, 1'b0);
        cycles = 0;
        while (!irq && cycles < 2 * TICKS) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq) begin
            abort("irq_o never rose with the timer interrupt unmasked");
        end
        if (cycles != TICKS - 2) begin
            abort("irq_o did not rise on the edge where the count reached zero");
        end
        @(negedge clk);
        irq_ack = 1'b1;
        irq_id  = 5'd3;
        @(negedge clk);
        irq_ack = 1'b0;
        check_bit("irq_o", irq, 1'b0);
        // with the mask cleared the expiry stays silent
        write_word(`MM_TIMER_BASE, 4'hF, '0);
        write_word(`MM_TIMER_BASE + 32'h4, 4'hF, TICKS);
        for (int i = 0; i < 2 * TICKS; i++) begin
            @(negedge clk);
            check_bit("irq_o", irq, 1'b0);
        end
    endtask

    initial begin
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_addr  = '0;
        data_we    = 1'b0;
        data_be    = '0;
        data_wdata = '0;
        irq_ack    = 1'b0;
        irq_id     = '0;
        void'($urandom(77352));

        reset_state_test();
        sram_test();
        rom_unmapped_test();
        stdout_test();
        timer_irq_test();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: mm_ram.f
+incdir+common
common/mm_ram_pkg.sv
ram/dp_ram.sv
hdl/mm_decoder.sv
hdl/mm_timer.sv
hdl/mm_rsp_mux.sv
hdl/mm_ram.sv
verification/tb_clk_gen.sv
verification/tb_mm_ram.sv
